// ==== include/cpu_cfg.svh ====
`ifndef CPU_CFG_SVH
`define CPU_CFG_SVH

// word address of the first instruction after reset
`define RESET_PC 32'h0000_0000

// word address of the common exception handler
`define EXC_HANDLER_PC 32'h0000_0100

// register file address width, 32 registers
`define REG_ADDR_W 5

`endif

// ==== src/cpu_pkg.sv ====
`include "cpu_cfg.svh"

package cpu_pkg;

    typedef enum logic [5:0] {
        OP_SPECIAL = 6'h00,
        OP_BEQ     = 6'h04,
        OP_BNE     = 6'h05,
        OP_ADDIU   = 6'h09,
        OP_LUI     = 6'h0f,
        OP_COP0    = 6'h10,
        OP_LW      = 6'h23,
        OP_SW      = 6'h2b
    } opcodeT;

    typedef enum logic [5:0] {
        FN_SRL  = 6'h02,
        FN_ERET = 6'h18,
        FN_ADDU = 6'h21,
        FN_SUBU = 6'h23,
        FN_OR   = 6'h25,
        FN_SLTU = 6'h2b
    } functT;

    typedef enum logic [2:0] {
        ALU_ADD  = 3'd0,
        ALU_SUB  = 3'd1,
        ALU_OR   = 3'd2,
        ALU_SRL  = 3'd3,
        ALU_SLTU = 3'd4,
        ALU_LUI  = 3'd5
    } aluOpT;

    // rs field values of the coprocessor 0 forms
    localparam logic [`REG_ADDR_W-1:0] COP0_MF = 5'h00;
    localparam logic [`REG_ADDR_W-1:0] COP0_MT = 5'h04;
    localparam logic [`REG_ADDR_W-1:0] COP0_CO = 5'h10;   // eret lives here

    localparam logic [4:0] CP0_STATUS = 5'd12;
    localparam logic [4:0] CP0_CAUSE  = 5'd13;
    localparam logic [4:0] CP0_EPC    = 5'd14;

    localparam logic [4:0] EXC_INT = 5'd0;    // external interrupt
    localparam logic [4:0] EXC_RI  = 5'd10;   // reserved instruction

    typedef struct packed {
        logic [`REG_ADDR_W-1:0] rd;
        logic [4:0]             shamt;
        functT                  funct;
    } rTypeT;

    // low half is either rd/shamt/funct or the immediate
    typedef union packed {
        rTypeT       rType;
        logic [15:0] imm;
    } lowHalfT;

    typedef struct packed {
        opcodeT                 opcode;
        logic [`REG_ADDR_W-1:0] rs;
        logic [`REG_ADDR_W-1:0] rt;
        lowHalfT                lowHalf;
    } instrFieldsT;

    typedef struct packed {
        logic  branch;
        logic  branchOnZero;    // beq when set, bne when clear
        logic  regDst;          // write rd instead of rt
        logic  regWrite;
        logic  aluSrc;          // immediate as second operand
        aluOpT aluOp;
        logic  memWrite;
        logic  memToReg;
        logic  cp0ToReg;
        logic  cp0Write;
        logic  eret;
        logic  reservedInstr;
    } ctrlWordT;

endpackage

// ==== src/instrDecoder.sv ====
`timescale 1ns/10ps

module instrDecoder import cpu_pkg::*; (
    input  instrFieldsT instr,
    output ctrlWordT    ctrl
);
    logic legal;

    always_comb begin
        ctrl       = '0;
        ctrl.aluOp = ALU_ADD;
        legal      = 1'b1;

        case (instr.opcode)
            OP_SPECIAL: begin
                ctrl.regDst   = 1'b1;
                ctrl.regWrite = 1'b1;
                case (instr.lowHalf.rType.funct)
                    FN_ADDU: ctrl.aluOp = ALU_ADD;
                    FN_SUBU: ctrl.aluOp = ALU_SUB;
                    FN_OR:   ctrl.aluOp = ALU_OR;
                    FN_SRL:  ctrl.aluOp = ALU_SRL;
                    FN_SLTU: ctrl.aluOp = ALU_SLTU;
                    default: legal = 1'b0;
                endcase
            end
            OP_ADDIU: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluSrc   = 1'b1;
            end
            OP_LUI: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluSrc   = 1'b1;
                ctrl.aluOp    = ALU_LUI;
            end
            OP_LW: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluSrc   = 1'b1;
                ctrl.memToReg = 1'b1;
            end
            OP_SW: begin
                ctrl.memWrite = 1'b1;
                ctrl.aluSrc   = 1'b1;
            end
            OP_BEQ, OP_BNE: begin
                ctrl.branch       = 1'b1;
                ctrl.branchOnZero = (instr.opcode == OP_BEQ);
                ctrl.aluOp        = ALU_SUB;     // compare rs and rt
            end
            OP_COP0: begin
                if (instr.rs == COP0_MF) begin
                    ctrl.cp0ToReg = 1'b1;
                    ctrl.regWrite = 1'b1;        // mfc0 writes rt
                end else if (instr.rs == COP0_MT) begin
                    ctrl.cp0Write = 1'b1;
                end else if (instr.rs == COP0_CO && instr.lowHalf.rType.funct == FN_ERET) begin
                    ctrl.eret = 1'b1;
                end else begin
                    legal = 1'b0;
                end
            end
            default: legal = 1'b0;
        endcase

        // anything unmatched becomes a bare reserved-instruction request
        if (!legal) begin
            ctrl               = '0;
            ctrl.aluOp         = ALU_ADD;
            ctrl.reservedInstr = 1'b1;
        end
    end

endmodule

// ==== src/alu.sv ====
`timescale 1ns/10ps

module alu import cpu_pkg::*; (
    input  logic [31:0] srcA,
    input  logic [31:0] srcB,
    input  aluOpT       op,
    input  logic [4:0]  shamt,
    output logic [31:0] result,
    output logic        zero
);
    always_comb begin
        case (op)
            ALU_ADD:  result = srcA + srcB;
            ALU_SUB:  result = srcA - srcB;
            ALU_OR:   result = srcA | srcB;
            ALU_SRL:  result = srcB >> shamt;          // shifts rt
            ALU_SLTU: result = {31'd0, srcA < srcB};
            ALU_LUI:  result = {srcB[15:0], 16'd0};
            default:  result = srcA + srcB;
        endcase
    end

    assign zero = (result == 32'd0);   // branch compare

endmodule

// ==== src/registerFile.sv ====
`timescale 1ns/10ps
`include "cpu_cfg.svh"

module registerFile (
    input  logic                   clk,
    input  logic [`REG_ADDR_W-1:0] dbgAddr,
    input  logic [`REG_ADDR_W-1:0] rsAddr,
    input  logic [`REG_ADDR_W-1:0] rtAddr,
    input  logic [`REG_ADDR_W-1:0] wrAddr,
    output logic [31:0]            dbgData,
    output logic [31:0]            rsData,
    output logic [31:0]            rtData,
    input  logic [31:0]            wrData,
    input  logic                   wrEn
);
    logic [31:0] regs [0:(1 << `REG_ADDR_W) - 1];

    // register zero is never stored, only masked on read
    assign dbgData = (dbgAddr != '0) ? regs[dbgAddr] : 32'd0;
    assign rsData  = (rsAddr != '0) ? regs[rsAddr] : 32'd0;
    assign rtData  = (rtAddr != '0) ? regs[rtAddr] : 32'd0;

    always_ff @(posedge clk) begin
        if (wrEn && wrAddr != '0) begin
            regs[wrAddr] <= wrData;
        end
    end

endmodule

// ==== src/coprocessor0.sv ====
`timescale 1ns/10ps

module coprocessor0 import cpu_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic [31:0] pc,
    input  logic [31:0] flowPc,
    input  logic [4:0]  regNum,
    input  logic [31:0] regWData,
    input  logic        regWrite,
    input  logic        eret,
    input  logic        reservedInstr,
    input  logic        irq,
    output logic [31:0] regRData,
    output logic [31:0] epc,
    output logic        excTaken,
    output logic        eretTaken
);
    logic       statusIe;     // Status bit 0
    logic       statusExl;    // Status bit 1
    logic       causeIp;      // Cause bit 10, sampled irq
    logic [4:0] causeCode;    // Cause bits 6:2
    logic       irqReq;

    assign irqReq    = irq & statusIe & ~statusExl;
    assign excTaken  = reservedInstr | irqReq;      // reserved instruction wins
    assign eretTaken = eret & ~excTaken;

    always_ff @(posedge clk) begin
        if (reset) begin
            statusIe  <= 1'b0;
            statusExl <= 1'b0;
            causeIp   <= 1'b0;
            causeCode <= EXC_INT;
        end else begin
            causeIp <= irq;
            if (excTaken) begin
                statusExl <= 1'b1;
                causeCode <= reservedInstr ? EXC_RI : EXC_INT;
            end else if (eretTaken) begin
                statusExl <= 1'b0;
            end else if (regWrite && regNum == CP0_STATUS) begin
                statusIe  <= regWData[0];
                statusExl <= regWData[1];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (excTaken) begin
            epc <= reservedInstr ? pc : flowPc;   // interrupt resumes at flow target
        end else if (regWrite && regNum == CP0_EPC) begin
            epc <= regWData;
        end
    end

    always_comb begin
        case (regNum)
            CP0_STATUS: regRData = {30'd0, statusExl, statusIe};
            CP0_CAUSE:  regRData = {21'd0, causeIp, 3'd0, causeCode, 2'd0};
            CP0_EPC:    regRData = epc;
            default:    regRData = 32'd0;
        endcase
    end

    // the decoder never flags an eret as a reserved instruction
    assert property (@(posedge clk) disable iff (reset) !(eret && reservedInstr));

    // no second interrupt right after one is taken
    assert property (@(posedge clk) disable iff (reset)
        (excTaken && !reservedInstr) |=> (!excTaken || reservedInstr));

endmodule

// ==== src/cpuCore.sv ====
`timescale 1ns/10ps
`include "cpu_cfg.svh"

module cpuCore import cpu_pkg::*; (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   irq,
    input  logic [`REG_ADDR_W-1:0] regAddr,
    output logic [31:0]            regData,
    output logic [31:0]            imAddr,
    input  logic [31:0]            imData,
    output logic [31:0]            dmAddr,
    output logic                   dmWe,
    output logic [31:0]            dmWData,
    input  logic [31:0]            dmRData
);
    instrFieldsT            instr;
    ctrlWordT               ctrl;
    logic [31:0]            pc;
    logic [31:0]            pcPlusOne;
    logic [31:0]            pcBranch;
    logic [31:0]            pcFlow;
    logic [31:0]            pcNext;
    logic [31:0]            signImm;
    logic [31:0]            rsData;
    logic [31:0]            rtData;
    logic [31:0]            dbgData;
    logic [31:0]            srcB;
    logic [31:0]            aluResult;
    logic                   aluZero;
    logic                   branchTaken;
    logic [`REG_ADDR_W-1:0] wrAddr;
    logic [31:0]            wbData;
    logic [31:0]            cp0RData;
    logic [31:0]            epc;
    logic                   excTaken;
    logic                   eretTaken;

    assign instr   = instrFieldsT'(imData);
    assign imAddr  = pc;
    assign signImm = {{16{instr.lowHalf.imm[15]}}, instr.lowHalf.imm};

    instrDecoder decoder0 (.instr(instr), .ctrl(ctrl));

    // word addressed, so the flow step is one
    assign pcPlusOne   = pc + 32'd1;
    assign pcBranch    = pcPlusOne + signImm;
    assign branchTaken = ctrl.branch & (aluZero == ctrl.branchOnZero);
    assign pcFlow      = branchTaken ? pcBranch : pcPlusOne;

    always_comb begin
        if (excTaken)
            pcNext = `EXC_HANDLER_PC;
        else if (eretTaken)
            pcNext = epc;
        else
            pcNext = pcFlow;   // sequential or branch target
    end

    always_ff @(posedge clk) begin
        if (reset)
            pc <= `RESET_PC;
        else
            pc <= pcNext;
    end

    assign wrAddr = ctrl.regDst ? instr.lowHalf.rType.rd : instr.rt;
    assign wbData = ctrl.memToReg ? dmRData : (ctrl.cp0ToReg ? cp0RData : aluResult);

    registerFile regFile0 (
        .clk     (clk),
        .dbgAddr (regAddr),
        .rsAddr  (instr.rs),
        .rtAddr  (instr.rt),
        .wrAddr  (wrAddr),
        .dbgData (dbgData),
        .rsData  (rsData),
        .rtData  (rtData),
        .wrData  (wbData),
        .wrEn    (ctrl.regWrite & ~excTaken)    // faulting instruction retires nothing
    );

    assign regData = (regAddr != '0) ? dbgData : pc;   // address zero shows pc

    assign srcB = ctrl.aluSrc ? signImm : rtData;

    alu alu0 (
        .srcA   (rsData),
        .srcB   (srcB),
        .op     (ctrl.aluOp),
        .shamt  (instr.lowHalf.rType.shamt),
        .result (aluResult),
        .zero   (aluZero)
    );

    assign dmAddr  = aluResult;
    assign dmWData = rtData;
    assign dmWe    = ctrl.memWrite & ~excTaken;

    coprocessor0 cp0 (
        .clk           (clk),
        .reset         (reset),
        .pc            (pc),
        .flowPc        (pcFlow),
        .regNum        (instr.lowHalf.rType.rd),
        .regWData      (rtData),
        .regWrite      (ctrl.cp0Write & ~excTaken),
        .eret          (ctrl.eret),
        .reservedInstr (ctrl.reservedInstr),
        .irq           (irq),
        .regRData      (cp0RData),
        .epc           (epc),
        .excTaken      (excTaken),
        .eretTaken     (eretTaken)
    );

    // the store strobe must resolve from whatever the memory returns
    assert property (@(posedge clk) disable iff (reset) !$isunknown(dmWe));

endmodule

// ==== tb/clockGen.sv ====
`timescale 1ns/10ps

module clockGen (
    output logic clk,
    output logic reset
);
    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;    // 4 ns period
    end

    initial begin
        reset = 1'b1;
        repeat (16) @(posedge clk);
        reset <= 1'b0;
    end

endmodule

// ==== tb/coreChecker.sv ====
`timescale 1ns/10ps
`include "cpu_cfg.svh"

module coreChecker (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   irq,
    input  logic [31:0]            imAddr,
    input  logic [31:0]            imData,
    input  logic [31:0]            dmAddr,
    input  logic                   dmWe,
    input  logic [31:0]            dmWData,
    input  logic [31:0]            dmRData,
    input  logic [`REG_ADDR_W-1:0] regAddr,
    input  logic [31:0]            regData,
    input  logic                   dbgCheck,
    output int                     errCount
);
    logic [31:0] regs [0:31];
    logic [31:0] mem [0:1023];
    logic [31:0] pc;
    logic [31:0] epc;
    logic        ie;
    logic        exl;
    logic        ip;          // irq seen in the previous cycle
    logic [4:0]  code;

    function automatic logic [31:0] memFill(input logic [9:0] a);
        return {6'h15, a, 6'h2a, ~a};
    endfunction

    task automatic expectEq(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp) begin
            $display("FAIL %s expected %h actual %h at pc %h", name, exp, act, pc);
            errCount++;
        end
    endtask

    always @(posedge clk) begin
        logic [5:0]  op;
        logic [5:0]  fn;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [4:0]  rd;
        logic [4:0]  wrAddr;
        logic [31:0] imm;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] res;
        logic [31:0] addr;
        logic [31:0] flow;
        logic [31:0] cpRead;
        logic        ri;
        logic        intr;
        logic        wr;
        logic        store;
        logic        mtc0;
        logic        eret;

        if (reset) begin
            pc       = `RESET_PC;
            epc      = 32'd0;
            ie       = 1'b0;
            exl      = 1'b0;
            ip       = 1'b0;
            code     = 5'd0;
            errCount = 0;
            for (int i = 0; i < 32; i++) regs[i] = 32'd0;
            for (int i = 0; i < 1024; i++) mem[i] = memFill(10'(i));
        end else begin
            if (dbgCheck) begin
                expectEq("regData", (regAddr == 5'd0) ? pc : regs[regAddr], regData);
            end
            expectEq("imAddr", pc, imAddr);

            op   = imData[31:26];
            rs   = imData[25:21];
            rt   = imData[20:16];
            rd   = imData[15:11];
            fn   = imData[5:0];
            imm  = {{16{imData[15]}}, imData[15:0]};
            a    = regs[rs];
            b    = regs[rt];
            addr = a + imm;
            flow = pc + 32'd1;
            res  = 32'd0;
            wrAddr = rt;
            {ri, wr, store, mtc0, eret} = 5'b0;

            case (rd)
                5'd12:   cpRead = {30'd0, exl, ie};
                5'd13:   cpRead = {21'd0, ip, 3'd0, code, 2'd0};
                5'd14:   cpRead = epc;
                default: cpRead = 32'd0;
            endcase

            case (op)
                6'h00: begin
                    wrAddr = rd;
                    wr     = 1'b1;
                    case (fn)
                        6'h21:   res = a + b;
                        6'h23:   res = a - b;
                        6'h25:   res = a | b;
                        6'h02:   res = b >> imData[10:6];
                        6'h2b:   res = (a < b) ? 32'd1 : 32'd0;
                        default: ri = 1'b1;
                    endcase
                end
                6'h09: begin
                    res = a + imm;
                    wr  = 1'b1;
                end
                6'h0f: begin
                    res = {imData[15:0], 16'd0};
                    wr  = 1'b1;
                end
                6'h23: begin
                    res = mem[addr[9:0]];
                    wr  = 1'b1;
                    expectEq("dmRData", res, dmRData);
                end
                6'h2b: store = 1'b1;
                6'h04: if (a == b) flow = pc + 32'd1 + imm;
                6'h05: if (a != b) flow = pc + 32'd1 + imm;
                6'h10: begin
                    if (rs == 5'h00) begin
                        res = cpRead;
                        wr  = 1'b1;
                    end else if (rs == 5'h04) begin
                        mtc0 = 1'b1;
                    end else if (rs == 5'h10 && fn == 6'h18) begin
                        eret = 1'b1;
                    end else begin
                        ri = 1'b1;
                    end
                end
                default: ri = 1'b1;
            endcase

            intr = irq && ie && !exl;
            expectEq("dmWe", {31'd0, store && !ri && !intr}, {31'd0, dmWe});
            if (store && !intr) begin
                expectEq("dmAddr", addr, dmAddr);
                expectEq("dmWData", b, dmWData);
            end

            if (ri || intr) begin
                epc  = ri ? pc : flow;
                exl  = 1'b1;
                code = ri ? 5'd10 : 5'd0;
                pc   = `EXC_HANDLER_PC;
            end else begin
                if (wr && wrAddr != 5'd0) regs[wrAddr] = res;
                if (store) mem[addr[9:0]] = b;
                if (mtc0 && rd == 5'd12) begin
                    ie  = b[0];
                    exl = b[1];
                end
                if (mtc0 && rd == 5'd14) epc = b;
                pc = eret ? epc : flow;
                if (eret) exl = 1'b0;
            end
            ip = irq;
        end
    end

endmodule

// ==== tb/tbTop.sv ====
`timescale 1ns/10ps
`include "cpu_cfg.svh"

module tbTop;
    localparam logic [31:0] NOP  = 32'h0000_0021;   // addu r0, r0, r0
    localparam logic [31:0] LOOP = 32'h1000_ffff;   // beq r0, r0, -1
    localparam int NUM_TESTS = 7;

    logic        clk;
    logic        reset;
    logic        irq;
    logic [4:0]  regAddr;
    logic [31:0] regData;
    logic [31:0] imAddr;
    logic [31:0] imData;
    logic [31:0] dmAddr;
    logic [31:0] dmWData;
    logic [31:0] dmRData;
    logic        dmWe;
    logic        dbgCheck;
    int          errCount;

    logic [31:0] imem [0:1023];
    logic [31:0] dmem [0:1023];
    logic [31:0] rngState;
    logic [31:0] loopAddr [0:NUM_TESTS-1];
    logic [31:0] irqAddr [0:NUM_TESTS-1];    // zero when the test has no irq
    int          expVisits [0:NUM_TESTS-1];
    string       testName [0:NUM_TESTS-1];
    int          fillAddr;
    int          totalInstr;
    int          handlerVisits = 0;
    logic        programBuilt = 1'b0;

    clockGen clockGen0 (.clk(clk), .reset(reset));

    cpuCore dut0 (
        .clk     (clk),
        .reset   (reset),
        .irq     (irq),
        .regAddr (regAddr),
        .regData (regData),
        .imAddr  (imAddr),
        .imData  (imData),
        .dmAddr  (dmAddr),
        .dmWe    (dmWe),
        .dmWData (dmWData),
        .dmRData (dmRData)
    );

    coreChecker checker0 (
        .clk      (clk),
        .reset    (reset),
        .irq      (irq),
        .imAddr   (imAddr),
        .imData   (imData),
        .dmAddr   (dmAddr),
        .dmWe     (dmWe),
        .dmWData  (dmWData),
        .dmRData  (dmRData),
        .regAddr  (regAddr),
        .regData  (regData),
        .dbgCheck (dbgCheck),
        .errCount (errCount)
    );

    assign imData  = imem[imAddr[9:0]];
    assign dmRData = dmem[dmAddr[9:0]];

    function automatic logic [31:0] memFill(input logic [9:0] a);
        return {6'h15, a, 6'h2a, ~a};
    endfunction

    always @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 1024; i++) dmem[i] <= memFill(10'(i));
        end else if (dmWe) begin
            dmem[dmAddr[9:0]] <= dmWData;
        end
    end

    always @(posedge clk) begin
        if (!reset && imAddr == `EXC_HANDLER_PC) handlerVisits <= handlerVisits + 1;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function logic [31:0] drawRandom();
        rngState = xorshift32(rngState);
        return rngState;
    endfunction

    function automatic logic [4:0] pickReg(input logic [7:0] b);
        return 5'(b % 8'd7) + 5'd1;    // r1 to r7
    endfunction

    function automatic logic [31:0] iWord(input logic [5:0] op, input logic [4:0] rs,
                                          input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [31:0] cp0Word(input logic [4:0] form, input logic [4:0] rt,
                                            input logic [4:0] rd);
        return {6'h10, form, rt, rd, 11'd0};
    endfunction

    function automatic logic [31:0] arithWord(input logic [31:0] r);
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        rs = pickReg(r[23:16]);
        rt = pickReg(r[7:0]);
        rd = pickReg(r[28:21]);
        case (r[31:29])
            3'd0:    return {6'h00, rs, rt, rd, 5'd0, 6'h21};
            3'd1:    return {6'h00, rs, rt, rd, 5'd0, 6'h23};
            3'd2:    return {6'h00, rs, rt, rd, 5'd0, 6'h25};
            3'd3:    return {6'h00, rs, rt, rd, 5'd0, 6'h2b};
            3'd4:    return {6'h00, 5'd0, rt, rd, r[14:10], 6'h02};
            3'd5:    return iWord(6'h0f, 5'd0, rt, r[15:0]);
            default: return iWord(6'h09, rs, rt, r[15:0]);
        endcase
    endfunction

    // base is r0, so the immediate is the word address
    function automatic logic [31:0] memWord(input logic [31:0] r);
        return {r[31] ? 6'h2b : 6'h23, 5'd0, pickReg(r[7:0]), 10'd0, r[13:8]};
    endfunction

    function automatic logic [31:0] branchWord(input logic [31:0] r);
        logic [4:0] rs;
        logic [4:0] rt;
        logic [1:0] off;
        rs  = pickReg(r[23:16]);
        rt  = r[30] ? rs : pickReg(r[7:0]);
        off = (r[9:8] == 2'd3) ? 2'd0 : r[9:8];    // forward only, 0 to 2
        return {r[31] ? 6'h04 : 6'h05, rs, rt, 14'd0, off};
    endfunction

    function automatic logic legalOpcode(input logic [5:0] op);
        return op inside {6'h00, 6'h04, 6'h05, 6'h09, 6'h0f, 6'h10, 6'h23, 6'h2b};
    endfunction

    function logic [31:0] illegalWord();
        logic [31:0] r;
        do r = drawRandom(); while (legalOpcode(r[31:26]));
        return r;
    endfunction

    task automatic emit(input logic [31:0] word);
        imem[fillAddr] = word;
        fillAddr++;
        totalInstr++;
    endtask

    task automatic closeSegment(input int idx, input string name, input int visits);
        loopAddr[idx]  = 32'(fillAddr);
        testName[idx]  = name;
        expVisits[idx] = visits;
        emit(LOOP);
    endtask

    task automatic emitArith(input int count);
        logic [31:0] r;
        for (int i = 0; i < count; i++) begin
            r = drawRandom();
            emit(arithWord(r));
        end
    endtask

    task automatic buildProgram();
        logic [31:0] r;
        int k;
        for (int i = 0; i < 1024; i++) imem[i] = {6'h3f, 16'd0, 10'(i)};   // traps if fetched
        for (int i = 0; i < NUM_TESTS; i++) irqAddr[i] = 32'd0;
        totalInstr = 0;

        // handler saves Cause and EPC in r6, r7 and resumes one past EPC
        fillAddr = int'(`EXC_HANDLER_PC);
        emit(cp0Word(5'h00, 5'd6, 5'd13));
        emit(cp0Word(5'h00, 5'd7, 5'd14));
        emit(iWord(6'h09, 5'd7, 5'd7, 16'd1));
        emit(cp0Word(5'h04, 5'd7, 5'd14));
        emit({6'h10, 5'h10, 15'd0, 6'h18});

        fillAddr = int'(`RESET_PC);
        for (int i = 1; i <= 7; i++) begin
            r = drawRandom();
            emit(iWord(6'h09, 5'd0, 5'(i), r[15:0]));
        end
        emitArith(40);
        closeSegment(0, "arith", 0);

        for (int i = 0; i < 40; i++) begin
            r = drawRandom();
            emit((r[28] | r[27]) ? memWord(r) : arithWord(r));
        end
        closeSegment(1, "memory", 0);

        // no branch in the last three slots, targets stay before the loop
        for (int i = 0; i < 40; i++) begin
            r = drawRandom();
            emit((i < 37 && r[28]) ? branchWord(r) : arithWord(r));
        end
        closeSegment(2, "branch", 0);

        k = fillAddr + 7;    // eret target
        emit(iWord(6'h09, 5'd0, 5'd1, 16'(k)));
        emit(cp0Word(5'h04, 5'd1, 5'd14));
        emit(iWord(6'h09, 5'd0, 5'd2, 16'd2));
        emit(cp0Word(5'h04, 5'd2, 5'd12));    // exception level on
        emit(cp0Word(5'h00, 5'd3, 5'd12));
        emit({6'h10, 5'h10, 15'd0, 6'h18});
        emit(iWord(6'h09, 5'd0, 5'd4, 16'h7777));   // skipped
        emit(cp0Word(5'h00, 5'd5, 5'd12));
        emit(cp0Word(5'h00, 5'd6, 5'd14));
        closeSegment(3, "cop0", 0);

        r = drawRandom();
        k = int'(r[7:0]) % 20;
        for (int i = 0; i < 24; i++) begin
            if (i == k) emit(illegalWord());
            else emitArith(1);
        end
        closeSegment(4, "reserved", 1);

        r = drawRandom();
        irqAddr[5] = 32'(fillAddr) + 32'(int'(r[3:0]) + 2);
        emitArith(24);
        closeSegment(5, "irqOff", 0);

        emit(iWord(6'h09, 5'd0, 5'd1, 16'd1));
        emit(cp0Word(5'h04, 5'd1, 5'd12));    // interrupt enable
        r = drawRandom();
        irqAddr[6] = 32'(fillAddr) + 32'(r[3:0]);
        emitArith(22);
        closeSegment(6, "irqOn", 1);
    endtask

    task automatic waitForPc(input logic [31:0] addr);
        while (imAddr !== addr) @(negedge clk);
    endtask

    task automatic pulseIrq(input logic [31:0] addr);
        waitForPc(addr);
        @(posedge clk);
        irq <= 1'b1;
        @(posedge clk);
        irq <= 1'b0;
        @(negedge clk);
    endtask

    // sweeps pc and r1 to r7 through the debug port while the core spins
    task automatic compareRegisters();
        for (int a = 0; a < 8; a++) begin
            @(posedge clk);
            regAddr  <= 5'(a);
            dbgCheck <= 1'b1;
        end
        @(posedge clk);
        dbgCheck <= 1'b0;
        @(negedge clk);
    endtask

    initial begin
        longint watchdogNs;
        wait (programBuilt);
        watchdogNs = longint'(totalInstr + NUM_TESTS * 24 + 16) * 4 + 400;
        #(watchdogNs);
        $display("Watchdog expired before the last test reached its end loop");
        $display("Some tests failed");
        $finish;
    end

    initial begin
        int errMark;
        int visitMark;
        int visits;
        int testErrors;
        int passedCount;
        irq      = 1'b0;
        regAddr  = 5'd0;
        dbgCheck = 1'b0;
        rngState = 32'd43;
        passedCount = 0;
        buildProgram();
        programBuilt = 1'b1;

        @(negedge clk);
        while (reset) @(negedge clk);
        errMark   = errCount;
        visitMark = handlerVisits;

        for (int i = 0; i < NUM_TESTS; i++) begin
            if (irqAddr[i] != 32'd0) pulseIrq(irqAddr[i]);
            waitForPc(loopAddr[i]);
            compareRegisters();
            testErrors = errCount - errMark;
            visits     = handlerVisits - visitMark;
            if (visits != expVisits[i]) begin
                $display("%s: exception handler entered %0d times instead of %0d",
                         testName[i], visits, expVisits[i]);
                testErrors++;
            end
            errMark   = errCount;
            visitMark = handlerVisits;
            if (testErrors == 0) begin
                passedCount++;
                $display("%-9s ok", testName[i]);
            end else begin
                $display("%-9s failed with %0d errors", testName[i], testErrors);
            end
            @(posedge clk);
            imem[loopAddr[i]] <= NOP;    // let the core fall into the next segment
        end

        $display("tests %0d, passed %0d, failed %0d, mismatches %0d",
                 NUM_TESTS, passedCount, NUM_TESTS - passedCount, errCount);
        if (passedCount == NUM_TESTS && errCount == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// ==== sim.f ====
+incdir+include
src/cpu_pkg.sv
src/instrDecoder.sv
src/alu.sv
src/registerFile.sv
src/coprocessor0.sv
src/cpuCore.sv
tb/clockGen.sv
tb/coreChecker.sv
tb/tbTop.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f sim.f --top-module tbTop -Mdir obj_dir \
    && ./obj_dir/VtbTop | tee /dev/stderr | grep -q "All tests passed" \
    && echo "simulation run ok" \
    || { echo "simulation run reported a failure"; exit 1; }
